// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module soc_fabric_tb \
  -Mdir obj_dir -o soc_fabric_sim

./obj_dir/soc_fabric_sim 2>&1 | tee sim.log

if grep -qx "RESULT: PASS" sim.log; then
  echo "Simulation passed."
else
  echo "Simulation failed, see sim.log."
  exit 1
fi

// ==== source/arbiter.sv ====
`default_nettype none

module arbiter
  import soc_pkg::*;
(
  input  logic        reset,
  input  logic        clock,
  input  mem_in_type  imem_in,
  output mem_out_type imem_out,
  input  mem_in_type  dmem_in,
  output mem_out_type dmem_out,
  output mem_in_type  mem_in,
  input  mem_out_type mem_out
);

  logic busy;
  logic owner;  // High while dmem owns the target.
  logic pend_valid;
  logic pend_owner;
  mem_in_type pend_req;

  logic busy_n;
  logic owner_n;
  logic pend_valid_n;
  logic pend_owner_n;
  logic hold;
  logic accept;
  logic launch;

  assign accept = !pend_valid && (!busy || mem_out.mem_ready);  // Target free, slot empty.
  assign launch = pend_valid && !busy;

  always_comb begin
    mem_in = init_mem_in;
    busy_n = busy && !mem_out.mem_ready;
    owner_n = owner;
    pend_valid_n = pend_valid;
    pend_owner_n = pend_owner;
    hold = 1'b0;
    if (launch) begin
      mem_in = pend_req;
      busy_n = 1'b1;
      owner_n = pend_owner;
      pend_valid_n = 1'b0;
    end else if (accept && dmem_in.mem_valid) begin
      mem_in = dmem_in;
      busy_n = 1'b1;
      owner_n = 1'b1;
    end else if (accept && imem_in.mem_valid) begin
      mem_in = imem_in;
      busy_n = 1'b1;
      owner_n = 1'b0;
    end
    if (dmem_in.mem_valid && !accept) begin
      hold = 1'b1;
      pend_valid_n = 1'b1;
      pend_owner_n = 1'b1;
    end
    if (imem_in.mem_valid && !(accept && !dmem_in.mem_valid)) begin  // Loses to dmem.
      hold = 1'b1;
      pend_valid_n = 1'b1;
      pend_owner_n = 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= 1'b0;
      owner <= 1'b0;
      pend_valid <= 1'b0;
      pend_owner <= 1'b0;
    end else begin
      busy <= busy_n;
      owner <= owner_n;
      pend_valid <= pend_valid_n;
      pend_owner <= pend_owner_n;
    end
  end

  always_ff @(posedge clock) begin
    if (hold) begin
      pend_req <= pend_owner_n ? dmem_in : imem_in;
    end
  end

  assign imem_out = (busy && !owner) ? mem_out : init_mem_out;
  assign dmem_out = (busy && owner) ? mem_out : init_mem_out;

  // A master may reissue in its ready cycle only when nothing is held.
  assert property (@(posedge clock) disable iff (reset)
    imem_in.mem_valid |-> !(pend_valid && !pend_owner) &&
      !(busy && !owner && !(mem_out.mem_ready && !pend_valid)))
  else $error("imem request while one is outstanding");

  assert property (@(posedge clock) disable iff (reset)
    dmem_in.mem_valid |-> !(pend_valid && pend_owner) &&
      !(busy && owner && !(mem_out.mem_ready && !pend_valid)))
  else $error("dmem request while one is outstanding");

  assert property (@(posedge clock) disable iff (reset) mem_out.mem_ready |-> busy)
  else $error("target ready with no request in flight");

endmodule

`default_nettype wire

// ==== source/clint.sv ====
`default_nettype none

module clint
  import soc_pkg::*;
(
  input  logic        reset,
  input  logic        clock,
  input  mem_in_type  clint_in,
  output mem_out_type clint_out,
  output logic        clint_msip,
  output logic        clint_mtip
);

  logic msip;
  logic mtip;
  logic [63:0] mtime;
  logic [63:0] mtimecmp;
  logic [31:0] div_count;
  logic tick;
  logic write;
  logic ready;
  logic [31:0] rdata;

  assign tick = div_count == 32'(clint_divider - 1);
  assign write = clint_in.mem_valid && clint_in.mem_wstrb != 4'h0;  // Whole-word registers.

  always_ff @(posedge clock) begin
    if (reset) begin
      msip <= 1'b0;
      mtip <= 1'b0;
      mtime <= 64'h0;
      mtimecmp <= '1;
      div_count <= 32'h0;
      ready <= 1'b0;
    end else begin
      ready <= clint_in.mem_valid;
      div_count <= tick ? 32'h0 : div_count + 32'd1;
      if (tick) begin
        mtime <= mtime + 64'd1;
      end
      if (write) begin  // Later assignment beats the tick.
        case (clint_in.mem_addr)
          clint_msip_offset: msip <= clint_in.mem_wdata[0];
          clint_mtimecmp_offset: mtimecmp[31:0] <= clint_in.mem_wdata;
          clint_mtimecmp_offset + 32'd4: mtimecmp[63:32] <= clint_in.mem_wdata;
          clint_mtime_offset: mtime[31:0] <= clint_in.mem_wdata;
          clint_mtime_offset + 32'd4: mtime[63:32] <= clint_in.mem_wdata;
          default: ;
        endcase
      end
      mtip <= mtime >= mtimecmp;
    end
  end

  always_ff @(posedge clock) begin
    rdata <= 32'h0;
    if (clint_in.mem_valid && clint_in.mem_wstrb == 4'h0) begin
      case (clint_in.mem_addr)
        clint_msip_offset: rdata <= {31'h0, msip};
        clint_mtimecmp_offset: rdata <= mtimecmp[31:0];
        clint_mtimecmp_offset + 32'd4: rdata <= mtimecmp[63:32];
        clint_mtime_offset: rdata <= mtime[31:0];
        clint_mtime_offset + 32'd4: rdata <= mtime[63:32];
        default: ;  // Holes read as zero.
      endcase
    end
  end

  assign clint_out.mem_ready = ready;
  assign clint_out.mem_rdata = rdata;
  assign clint_msip = msip;
  assign clint_mtip = mtip;

endmodule

`default_nettype wire

// ==== source/mem_decoder.sv ====
`default_nettype none

module mem_decoder
  import soc_pkg::*;
(
  input  logic        reset,
  input  logic        clock,
  input  mem_in_type  mem_in,
  output mem_out_type mem_out,
  output mem_in_type  rom_in,
  output mem_in_type  ram_in,
  output mem_in_type  clint_in,
  input  mem_out_type rom_out,
  input  mem_out_type ram_out,
  input  mem_out_type clint_out
);

  logic hit;
  logic unmapped_ready;

  function automatic logic in_range(input logic [31:0] addr, input logic [31:0] base,
                                    input logic [31:0] top);
    return (addr >= base) && (addr < top);
  endfunction

  always_comb begin
    rom_in = init_mem_in;
    ram_in = init_mem_in;
    clint_in = init_mem_in;
    hit = 1'b0;
    if (mem_in.mem_valid) begin
      if (in_range(mem_in.mem_addr, rom_base_addr, rom_top_addr)) begin
        rom_in = mem_in;
        rom_in.mem_addr = mem_in.mem_addr - rom_base_addr;
        hit = 1'b1;
      end else if (in_range(mem_in.mem_addr, ram_base_addr, ram_top_addr)) begin
        ram_in = mem_in;
        ram_in.mem_addr = mem_in.mem_addr - ram_base_addr;
        hit = 1'b1;
      end else if (in_range(mem_in.mem_addr, clint_base_addr, clint_top_addr)) begin
        clint_in = mem_in;
        clint_in.mem_addr = mem_in.mem_addr - clint_base_addr;
        hit = 1'b1;
      end
    end
  end

  // Unmapped accesses are answered here with zero data.
  always_ff @(posedge clock) begin
    if (reset) begin
      unmapped_ready <= 1'b0;
    end else begin
      unmapped_ready <= mem_in.mem_valid && !hit;
    end
  end

  // Idle targets drive zero data, so the responses can simply be merged.
  always_comb begin
    mem_out.mem_ready = rom_out.mem_ready | ram_out.mem_ready | clint_out.mem_ready |
                        unmapped_ready;
    mem_out.mem_rdata = rom_out.mem_rdata | ram_out.mem_rdata | clint_out.mem_rdata;
  end

  // One outstanding request per master, so only one path answers.
  assert property (@(posedge clock) disable iff (reset)
    $onehot0({rom_out.mem_ready, ram_out.mem_ready, clint_out.mem_ready, unmapped_ready}))
  else $error("decoder saw more than one response at once");

endmodule

`default_nettype wire

// ==== source/ram.sv ====
`default_nettype none

module ram
  import soc_pkg::*;
(
  input  logic        reset,
  input  logic        clock,
  input  mem_in_type  ram_in,
  output mem_out_type ram_out
);

  logic [31:0] ram_array [ram_depth];
  logic [$clog2(ram_depth)-1:0] index;
  logic ready;
  logic [31:0] rdata;

  assign index = ram_in.mem_addr[$clog2(ram_depth)+1:2];

  always_ff @(posedge clock) begin
    if (reset) begin
      ready <= 1'b0;
    end else begin
      ready <= ram_in.mem_valid;
    end
  end

  always_ff @(posedge clock) begin
    rdata <= 32'h0;
    if (ram_in.mem_valid) begin
      if (ram_in.mem_wstrb == 4'h0) begin
        rdata <= ram_array[index];
      end
      for (int i = 0; i < 4; i++) begin
        if (ram_in.mem_wstrb[i]) begin
          ram_array[index][8*i +: 8] <= ram_in.mem_wdata[8*i +: 8];  // Byte lane i.
        end
      end
    end
  end

  assign ram_out.mem_ready = ready;
  assign ram_out.mem_rdata = rdata;

endmodule

`default_nettype wire

// ==== source/rom.sv ====
`default_nettype none

module rom
  import soc_pkg::*;
(
  input  logic        reset,
  input  logic        clock,
  input  mem_in_type  rom_in,
  output mem_out_type rom_out
);

  logic [31:0] rom_array [rom_depth];
  logic [$clog2(rom_depth)-1:0] index;
  logic ready;
  logic [31:0] rdata;

  for (genvar i = 0; i < rom_depth; i++) begin : g_content
    assign rom_array[i] = rom_word(i);
  end

  assign index = rom_in.mem_addr[$clog2(rom_depth)+1:2];

  always_ff @(posedge clock) begin
    if (reset) begin
      ready <= 1'b0;
    end else begin
      ready <= rom_in.mem_valid;  // Writes are dropped but acknowledged.
    end
  end

  always_ff @(posedge clock) begin
    rdata <= (rom_in.mem_valid && rom_in.mem_wstrb == 4'h0) ? rom_array[index] : 32'h0;
  end

  assign rom_out.mem_ready = ready;
  assign rom_out.mem_rdata = rdata;

endmodule

`default_nettype wire

// ==== source/soc_fabric.sv ====
`default_nettype none

module soc_fabric
  import soc_pkg::*;
(
  input  logic        reset,
  input  logic        clock,
  input  mem_in_type  imem_in,
  output mem_out_type imem_out,
  input  mem_in_type  dmem_in,
  output mem_out_type dmem_out,
  output logic        msip,
  output logic        mtip
);

  mem_in_type irom_in;
  mem_in_type iram_in;
  mem_in_type iclint_in;
  mem_in_type drom_in;
  mem_in_type dram_in;
  mem_in_type dclint_in;
  mem_in_type rom_in;
  mem_in_type ram_in;
  mem_in_type clint_in;

  mem_out_type irom_out;
  mem_out_type iram_out;
  mem_out_type iclint_out;
  mem_out_type drom_out;
  mem_out_type dram_out;
  mem_out_type dclint_out;
  mem_out_type rom_out;
  mem_out_type ram_out;
  mem_out_type clint_out;

  mem_decoder decoder_imem_comp (
    .reset(reset), .clock(clock), .mem_in(imem_in), .mem_out(imem_out),
    .rom_in(irom_in), .ram_in(iram_in), .clint_in(iclint_in),
    .rom_out(irom_out), .ram_out(iram_out), .clint_out(iclint_out)
  );

  mem_decoder decoder_dmem_comp (
    .reset(reset), .clock(clock), .mem_in(dmem_in), .mem_out(dmem_out),
    .rom_in(drom_in), .ram_in(dram_in), .clint_in(dclint_in),
    .rom_out(drom_out), .ram_out(dram_out), .clint_out(dclint_out)
  );

  arbiter arbiter_rom_comp (
    .reset(reset), .clock(clock), .imem_in(irom_in), .imem_out(irom_out),
    .dmem_in(drom_in), .dmem_out(drom_out), .mem_in(rom_in), .mem_out(rom_out)
  );

  arbiter arbiter_ram_comp (
    .reset(reset), .clock(clock), .imem_in(iram_in), .imem_out(iram_out),
    .dmem_in(dram_in), .dmem_out(dram_out), .mem_in(ram_in), .mem_out(ram_out)
  );

  arbiter arbiter_clint_comp (
    .reset(reset), .clock(clock), .imem_in(iclint_in), .imem_out(iclint_out),
    .dmem_in(dclint_in), .dmem_out(dclint_out), .mem_in(clint_in), .mem_out(clint_out)
  );

  rom rom_comp (.reset(reset), .clock(clock), .rom_in(rom_in), .rom_out(rom_out));

  ram ram_comp (.reset(reset), .clock(clock), .ram_in(ram_in), .ram_out(ram_out));

  clint clint_comp (
    .reset(reset), .clock(clock), .clint_in(clint_in), .clint_out(clint_out),
    .clint_msip(msip), .clint_mtip(mtip)
  );

endmodule

`default_nettype wire

// ==== source/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

  typedef struct packed {
    logic        mem_valid;
    logic        mem_instr;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_wstrb;
  } mem_in_type;

  typedef struct packed {
    logic        mem_ready;
    logic [31:0] mem_rdata;
  } mem_out_type;

  localparam mem_in_type init_mem_in = '0;
  localparam mem_out_type init_mem_out = '0;

  localparam logic [31:0] rom_base_addr = 32'h0000_0000;
  localparam logic [31:0] rom_top_addr = 32'h0000_0400;
  localparam logic [31:0] clint_base_addr = 32'h0200_0000;
  localparam logic [31:0] clint_top_addr = 32'h0200_C000;
  localparam logic [31:0] ram_base_addr = 32'h8000_0000;
  localparam logic [31:0] ram_top_addr = 32'h8000_1000;

  localparam int rom_depth = 256;
  localparam int ram_depth = 1024;

  localparam int clint_divider = 4;  // Clocks per mtime tick.

  localparam logic [31:0] clint_msip_offset = 32'h0000_0000;
  localparam logic [31:0] clint_mtimecmp_offset = 32'h0000_4000;
  localparam logic [31:0] clint_mtime_offset = 32'h0000_BFF8;

  // Index in the high half, scrambled inverse of it in the low half.
  function automatic logic [31:0] rom_word(input int unsigned index);
    logic [15:0] idx;
    logic [31:0] mix;
    idx = index[15:0];
    mix = {16'h0000, ~idx} * 32'h0000_9E37;
    return {idx, mix[15:0]};
  endfunction

endpackage

`default_nettype wire

// ==== sources.f ====
source/soc_pkg.sv
source/mem_decoder.sv
source/arbiter.sv
source/rom.sv
source/ram.sv
source/clint.sv
source/soc_fabric.sv
testbench/soc_fabric_tb.sv

// ==== testbench/soc_fabric_tb.sv ====
`default_nettype none

module soc_fabric_tb
  import soc_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  typedef enum logic [1:0] {port_imem, port_dmem, port_both} port_type;

  typedef struct packed {
    port_type    port;
    logic [31:0] addr;   // Dmem address on a both row.
    logic [31:0] addr2;  // Imem address on a both row.
    logic [3:0]  wstrb;
    logic [31:0] wdata;
    logic [31:0] exp;
    logic [31:0] exp2;
    logic        chk_msip;
    logic        msip_val;
  } row_type;

  logic clock = 1'b0;
  logic reset;
  mem_in_type imem_in;
  mem_in_type dmem_in;
  mem_out_type imem_out;
  mem_out_type dmem_out;
  logic msip;
  logic mtip;

  row_type rows[$];
  logic [31:0] ram_model [logic [31:0]];
  logic msip_model = 1'b0;
  logic [31:0] lfsr_state = 32'h6da3_2f3c;

  soc_fabric soc_fabric_inst (
    .reset(reset), .clock(clock), .imem_in(imem_in), .imem_out(imem_out),
    .dmem_in(dmem_in), .dmem_out(dmem_out), .msip(msip), .mtip(mtip)
  );

  always #50 clock = ~clock;

  function automatic logic lfsr_bit();
    logic lsb;
    lsb = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;  // Taps 32, 22, 2, 1.
    end
    return lsb;
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    w = 32'h0;
    for (int i = 0; i < 32; i++) begin
      w = {w[30:0], lfsr_bit()};
    end
    return w;
  endfunction

  // 0 ROM, 1 RAM, 2 CLINT, 3 nothing.
  function automatic logic [1:0] target_of(input logic [31:0] addr);
    if (addr >= rom_base_addr && addr < rom_top_addr) return 2'd0;
    if (addr >= ram_base_addr && addr < ram_top_addr) return 2'd1;
    if (addr >= clint_base_addr && addr < clint_top_addr) return 2'd2;
    return 2'd3;
  endfunction

  function automatic logic [31:0] expect_read(input logic [31:0] addr);
    case (target_of(addr))
      2'd0: return rom_word((addr - rom_base_addr) >> 2);
      2'd1: return ram_model.exists(addr) ? ram_model[addr] : 32'h0;
      2'd2: return (addr == clint_base_addr + clint_msip_offset) ? {31'h0, msip_model} : 32'h0;
      default: return 32'h0;
    endcase
  endfunction

  task automatic fail_check(input string msg);
    $display("ERR %0d ns: %s", $time, msg);
    $display("RESULT: FAIL");
    $fatal(1, "Stopping after a failed check.");
  endtask

  task automatic fail_timeout(input string msg);
    $display("Timeout: %s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "Stopping after a timeout.");
  endtask

  task automatic add_write(input logic [31:0] addr, input logic [3:0] wstrb,
                           input logic [31:0] wdata);
    row_type r;
    logic [31:0] merged;
    r = '0;
    r.port = port_dmem;
    r.addr = addr;
    r.wstrb = wstrb;
    r.wdata = wdata;
    if (target_of(addr) == 2'd1) begin
      merged = ram_model.exists(addr) ? ram_model[addr] : 32'h0;
      for (int i = 0; i < 4; i++) begin
        if (wstrb[i]) merged[8*i +: 8] = wdata[8*i +: 8];
      end
      ram_model[addr] = merged;
    end
    if (addr == clint_base_addr + clint_msip_offset) begin
      msip_model = wdata[0];
      r.chk_msip = 1'b1;
      r.msip_val = wdata[0];
    end
    rows.push_back(r);
  endtask

  task automatic add_read(input port_type port, input logic [31:0] addr);
    row_type r;
    r = '0;
    r.port = port;
    r.addr = addr;
    r.exp = expect_read(addr);
    r.chk_msip = addr == clint_base_addr + clint_msip_offset;
    r.msip_val = msip_model;
    rows.push_back(r);
  endtask

  task automatic add_pair(input logic [31:0] daddr, input logic [31:0] iaddr);
    row_type r;
    r = '0;
    r.port = port_both;
    r.addr = daddr;
    r.addr2 = iaddr;
    r.exp = expect_read(daddr);
    r.exp2 = expect_read(iaddr);
    rows.push_back(r);
  endtask

  task automatic build_table();
    add_read(port_imem, 32'h0000_0000);  // ROM through both ports.
    add_read(port_dmem, 32'h0000_0004);
    add_read(port_imem, 32'h0000_03FC);
    add_read(port_dmem, 32'h0000_0100);
    add_read(port_imem, 32'h0000_02A8);
    add_write(32'h8000_0000, 4'hF, rand_word());  // RAM full words, then bytes.
    add_write(32'h8000_0010, 4'hF, rand_word());
    add_write(32'h8000_0010, 4'b0100, rand_word());
    add_write(32'h8000_0FFC, 4'hF, rand_word());
    add_write(32'h8000_0FFC, 4'b1001, rand_word());
    add_read(port_imem, 32'h8000_0000);
    add_read(port_imem, 32'h8000_0010);
    add_read(port_imem, 32'h8000_0FFC);
    add_pair(32'h8000_0000, 32'h8000_0010);  // Same target.
    add_pair(32'h0000_0010, 32'h0000_0014);
    add_pair(32'h8000_0010, 32'h0000_0008);  // Different targets.
    add_read(port_imem, 32'h1000_0000);  // Unmapped.
    add_read(port_dmem, 32'h0000_0400);
    add_read(port_dmem, 32'h8000_1000);
    add_write(clint_base_addr + clint_msip_offset, 4'hF, 32'h0000_0001);
    add_read(port_dmem, clint_base_addr + clint_msip_offset);
    add_write(clint_base_addr + clint_msip_offset, 4'hF, 32'h0000_0000);
    add_read(port_imem, clint_base_addr + clint_msip_offset);
  endtask

  // Issues one row and waits for every ready it expects.
  task automatic run_access(input row_type r, output logic [31:0] drdata,
                            output logic [31:0] irdata, output int dlat, output int ilat);
    mem_in_type req;
    logic d_wait;
    logic i_wait;
    int cycles;
    d_wait = r.port != port_imem;
    i_wait = r.port != port_dmem;
    drdata = 32'h0;
    irdata = 32'h0;
    dlat = 0;
    ilat = 0;
    @(negedge clock);
    req = init_mem_in;
    req.mem_valid = 1'b1;
    req.mem_addr = r.addr;
    req.mem_wstrb = r.wstrb;
    req.mem_wdata = r.wdata;
    if (r.port == port_imem) begin
      req.mem_instr = 1'b1;
      imem_in = req;
    end else begin
      dmem_in = req;
      if (r.port == port_both) begin
        imem_in = init_mem_in;
        imem_in.mem_valid = 1'b1;
        imem_in.mem_instr = 1'b1;
        imem_in.mem_addr = r.addr2;
      end
    end
    cycles = 0;
    while ((d_wait || i_wait) && cycles < 20) begin
      @(negedge clock);
      cycles++;
      imem_in = init_mem_in;
      dmem_in = init_mem_in;
      if (d_wait && dmem_out.mem_ready) begin
        d_wait = 1'b0;
        dlat = cycles;
        drdata = dmem_out.mem_rdata;
      end else begin
        assert (!dmem_out.mem_ready) else fail_check("unexpected ready on dmem");
      end
      if (i_wait && imem_out.mem_ready) begin
        i_wait = 1'b0;
        ilat = cycles;
        irdata = imem_out.mem_rdata;
      end else begin
        assert (!imem_out.mem_ready) else fail_check("unexpected ready on imem");
      end
    end
    if (d_wait || i_wait) begin
      fail_timeout($sformatf("no mem_ready for the access to %h", r.addr));
    end
  endtask

  task automatic apply_row(input row_type r);
    logic [31:0] drdata;
    logic [31:0] irdata;
    int dlat;
    int ilat;
    run_access(r, drdata, irdata, dlat, ilat);
    if (r.port == port_imem) begin
      assert (irdata == r.exp && ilat == 1)
      else fail_check($sformatf("imem %h: rdata %h after %0d cycles, expected %h after 1",
                                r.addr, irdata, ilat, r.exp));
    end else begin
      assert (drdata == r.exp)
      else fail_check($sformatf("dmem %h: rdata %h, expected %h", r.addr, drdata, r.exp));
    end
    if (r.port == port_dmem) begin
      assert (dlat == 1)
      else fail_check($sformatf("dmem %h: ready after %0d cycles", r.addr, dlat));
    end
    if (r.port == port_both) begin
      assert (irdata == r.exp2)
      else fail_check($sformatf("imem %h: rdata %h, expected %h", r.addr2, irdata, r.exp2));
      if (target_of(r.addr) == target_of(r.addr2)) begin
        assert (dlat == 1 && ilat > 1)
        else fail_check($sformatf("conflict: dmem ready at %0d, imem at %0d", dlat, ilat));
      end else begin
        assert (dlat == 1 && ilat == 1)
        else fail_check($sformatf("no conflict: dmem ready at %0d, imem at %0d", dlat, ilat));
      end
    end
    if (r.chk_msip) begin
      assert (msip == r.msip_val)
      else fail_check($sformatf("msip is %b, expected %b", msip, r.msip_val));
    end
  endtask

  task automatic dmem_access(input logic [31:0] addr, input logic [3:0] wstrb,
                             input logic [31:0] wdata, output logic [31:0] rdata);
    row_type r;
    logic [31:0] irdata;
    int dlat;
    int ilat;
    r = '0;
    r.port = port_dmem;
    r.addr = addr;
    r.wstrb = wstrb;
    r.wdata = wdata;
    run_access(r, rdata, irdata, dlat, ilat);
    assert (dlat == 1) else fail_check($sformatf("dmem %h: ready after %0d cycles", addr, dlat));
  endtask

  task automatic check_timer();
    logic [31:0] lo1;
    logic [31:0] hi1;
    logic [31:0] lo2;
    logic [31:0] hi2;
    logic [31:0] rd;
    int waited;
    dmem_access(clint_base_addr + clint_mtime_offset, 4'h0, 32'h0, lo1);
    dmem_access(clint_base_addr + clint_mtime_offset + 32'd4, 4'h0, 32'h0, hi1);
    repeat (12) @(negedge clock);
    dmem_access(clint_base_addr + clint_mtime_offset, 4'h0, 32'h0, lo2);
    dmem_access(clint_base_addr + clint_mtime_offset + 32'd4, 4'h0, 32'h0, hi2);
    assert ({hi2, lo2} >= {hi1, lo1})
    else fail_check($sformatf("mtime went from %h%h to %h%h", hi1, lo1, hi2, lo2));
    dmem_access(clint_base_addr + clint_mtimecmp_offset, 4'hF, lo2 + 32'd8, rd);
    dmem_access(clint_base_addr + clint_mtimecmp_offset + 32'd4, 4'hF, hi2, rd);
    dmem_access(clint_base_addr + clint_mtimecmp_offset, 4'h0, 32'h0, rd);
    assert (rd == lo2 + 32'd8) else fail_check($sformatf("mtimecmp low reads %h", rd));
    waited = 0;
    while (!mtip && waited < 200) begin
      @(negedge clock);
      waited++;
    end
    if (!mtip) fail_timeout("mtip did not rise after mtimecmp was set just above mtime");
    dmem_access(clint_base_addr + clint_mtimecmp_offset + 32'd4, 4'hF, 32'hFFFF_FFFF, rd);
    dmem_access(clint_base_addr + clint_mtimecmp_offset, 4'hF, 32'hFFFF_FFFF, rd);
    waited = 0;
    while (mtip && waited < 10) begin
      @(negedge clock);
      waited++;
    end
    if (mtip) fail_timeout("mtip stayed high after mtimecmp was set to all ones");
  endtask

  initial begin
    reset = 1'b1;
    imem_in = init_mem_in;
    dmem_in = init_mem_in;
    build_table();
    repeat (2) @(negedge clock);
    reset = 1'b0;
    assert (!imem_out.mem_ready && !dmem_out.mem_ready && !msip && !mtip)
    else fail_check("outputs not idle after reset");
    foreach (rows[i]) begin
      apply_row(rows[i]);
    end
    check_timer();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire
